// File: sources.f
src/pipe_pkg.sv
src/load_use_detect.sv
src/long_stall_tracker.sv
src/hazard_combine.sv
src/pipe_hazard_top.sv
dv/pipe_hazard_props.sv
dv/tb_clock_gen.sv
dv/pipe_hazard_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pipe_hazard_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP BUILD_DIR FILELIST VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/pipe_hazard_tb.sv
module pipe_hazard_tb
    import pipe_pkg::*;
;

    localparam int WAIT_LIMIT = 16;

    typedef struct {
        string      name;
        logic [3:0] rd;      // m_rs, m_rt, s_rs, s_rt read enables
        reg_addr_t  m_rs, m_rt, s_rs, s_rt;
        logic       em_ld;
        reg_addr_t  em_wa;
        logic       es_ld;
        reg_addr_t  es_wa;
        logic       br;
        logic       exc;
        logic [4:0] exp_ena; // f d e m w
        logic [2:0] exp_flush; // d e m
    } row_t;

    logic clk, rst_n;
    logic d_m_read_rs, d_m_read_rt, d_s_read_rs, d_s_read_rt;
    reg_addr_t d_m_rs, d_m_rt, d_s_rs, d_s_rt;
    logic e_m_mem_to_reg, e_s_mem_to_reg;
    reg_addr_t e_m_waddr, e_s_waddr;
    logic e_branch_taken, m_except;
    logic icache_req, icache_ack, dcache_req, dcache_ack, mdu_req, mdu_ack;
    logic f_ena, d_ena, e_ena, m_ena, w_ena;
    logic d_flush, e_flush, m_flush;
    logic [NUM_AGENTS-1:0] proto_err;

    row_t table_q[$];

    tb_clock_gen clk_gen_inst (.clk(clk), .rst_n(rst_n));

    pipe_hazard_top pipe_hazard_top_inst (.*);

    task automatic add_row(input string name, input logic [3:0] rd,
                           input reg_addr_t m_rs, input reg_addr_t m_rt,
                           input reg_addr_t s_rs, input reg_addr_t s_rt,
                           input logic em_ld, input reg_addr_t em_wa,
                           input logic es_ld, input reg_addr_t es_wa,
                           input logic br, input logic exc,
                           input logic [4:0] exp_ena, input logic [2:0] exp_flush);
        row_t r;
        r = '{name, rd, m_rs, m_rt, s_rs, s_rt, em_ld, em_wa, es_ld, es_wa,
              br, exc, exp_ena, exp_flush};
        table_q.push_back(r);
    endtask

    task automatic check_ena(input string name, input logic [4:0] exp);
        logic [4:0] act;
        act = {f_ena, d_ena, e_ena, m_ena, w_ena};
        if (act !== exp) begin
            $display("Error %s: enables expected %b actual %b", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "enable mismatch");
        end
    endtask

    task automatic check_flush(input string name, input logic [2:0] exp);
        logic [2:0] act;
        act = {d_flush, e_flush, m_flush};
        if (act !== exp) begin
            $display("Error %s: flushes expected %b actual %b", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "flush mismatch");
        end
    endtask

    task automatic check_err(input string name, input logic [NUM_AGENTS-1:0] exp);
        if (proto_err !== exp) begin
            $display("Error %s: proto_err expected %b actual %b", name, exp, proto_err);
            $display("TESTBENCH FAILED");
            $fatal(1, "proto_err mismatch");
        end
    endtask

    task automatic set_req(input int agent, input logic v);
        case (agent)
            AGT_ICACHE: icache_req <= v;
            AGT_DCACHE: dcache_req <= v;
            default:    mdu_req    <= v;
        endcase
    endtask

    task automatic set_ack(input int agent, input logic v);
        case (agent)
            AGT_ICACHE: icache_ack <= v;
            AGT_DCACHE: dcache_ack <= v;
            default:    mdu_ack    <= v;
        endcase
    endtask

    // tb plays both requester and agent of one four-phase transfer
    task automatic run_handshake(input string name, input int agent, input int delay,
                                 input logic [4:0] wait_ena, input logic [2:0] exp_flush);
        int n;
        @(posedge clk);
        set_req(agent, 1'b1);
        for (int k = 0; k < delay; k++) begin
            @(negedge clk);
            check_ena(name, wait_ena);
            check_flush(name, exp_flush);
            @(posedge clk);
        end
        set_ack(agent, 1'b1);
        @(negedge clk);
        check_ena(name, wait_ena); // ack not sampled yet
        @(posedge clk);
        set_req(agent, 1'b0);
        n = 0;
        @(negedge clk);
        while ({f_ena, d_ena, e_ena, m_ena, w_ena} !== 5'b11111) begin
            n++;
            if (n >= WAIT_LIMIT) begin
                $display("TESTBENCH FAILED");
                $fatal(1, "%s: stall did not clear after ack", name);
            end
            @(negedge clk);
        end
        if (n != 0) begin
            $display("Error %s: stall release expected 0 extra cycles actual %0d", name, n);
            $display("TESTBENCH FAILED");
            $fatal(1, "late stall release");
        end
        @(posedge clk);
        set_ack(agent, 1'b0);
        @(negedge clk);
        check_ena(name, 5'b11111);
        check_err(name, '0);
    endtask

    initial begin
        int n;
        int delay;
        row_t r;

        void'($urandom(86));
        {d_m_read_rs, d_m_read_rt, d_s_read_rs, d_s_read_rt} = 4'b0000;
        d_m_rs = 5'd1;
        d_m_rt = 5'd2;
        d_s_rs = 5'd3;
        d_s_rt = 5'd4;
        {e_m_mem_to_reg, e_s_mem_to_reg} = 2'b00;
        e_m_waddr = 5'd10;
        e_s_waddr = 5'd11;
        {e_branch_taken, m_except} = 2'b00;
        {icache_req, icache_ack, dcache_req, dcache_ack, mdu_req, mdu_ack} = 6'b000000;

        // load-use over all four slot pairs and the flush rows
        add_row("lu_mm_rs", 4'b1000, 5, 2, 3, 4, 1, 5, 0, 11, 0, 0, 5'b10111, 3'b000);
        add_row("lu_mm_rt", 4'b0100, 1, 7, 3, 4, 1, 7, 0, 11, 0, 0, 5'b10111, 3'b000);
        add_row("lu_sm_rs", 4'b0010, 1, 2, 9, 4, 1, 9, 0, 11, 0, 0, 5'b10111, 3'b000);
        add_row("lu_sm_rt", 4'b0001, 1, 2, 3, 12, 1, 12, 0, 11, 0, 0, 5'b10111, 3'b000);
        add_row("lu_ms_rs", 4'b1000, 13, 2, 3, 4, 0, 10, 1, 13, 0, 0, 5'b10111, 3'b000);
        add_row("lu_ms_rt", 4'b0100, 1, 14, 3, 4, 0, 10, 1, 14, 0, 0, 5'b10111, 3'b000);
        add_row("lu_ss_rs", 4'b0010, 1, 2, 15, 4, 0, 10, 1, 15, 0, 0, 5'b10111, 3'b000);
        add_row("lu_ss_rt", 4'b0001, 1, 2, 3, 16, 0, 10, 1, 16, 0, 0, 5'b10111, 3'b000);
        add_row("lu_r0_dest", 4'b1111, 0, 0, 0, 0, 1, 0, 1, 0, 0, 0, 5'b11111, 3'b000);
        add_row("lu_read_off", 4'b0000, 5, 5, 5, 5, 1, 5, 1, 5, 0, 0, 5'b11111, 3'b000);
        add_row("lu_not_load", 4'b1111, 5, 6, 7, 8, 0, 5, 0, 8, 0, 0, 5'b11111, 3'b000);
        add_row("no_hazard", 4'b1111, 1, 2, 3, 4, 1, 10, 1, 11, 0, 0, 5'b11111, 3'b000);
        add_row("branch", 4'b0000, 1, 2, 3, 4, 0, 10, 0, 11, 1, 0, 5'b11111, 3'b110);
        add_row("except", 4'b0000, 1, 2, 3, 4, 0, 10, 0, 11, 0, 1, 5'b11111, 3'b111);
        add_row("branch_except", 4'b0000, 1, 2, 3, 4, 0, 10, 0, 11, 1, 1, 5'b11111, 3'b111);
        add_row("branch_lu", 4'b1000, 5, 2, 3, 4, 1, 5, 0, 11, 1, 0, 5'b10111, 3'b110);

        n = 0;
        while (rst_n !== 1'b1) begin
            n++;
            if (n >= WAIT_LIMIT) begin
                $display("TESTBENCH FAILED");
                $fatal(1, "reset never released");
            end
            @(posedge clk);
        end
        @(negedge clk);
        check_ena("after_reset", 5'b11111);
        check_err("after_reset", '0);

        foreach (table_q[i]) begin
            r = table_q[i];
            @(posedge clk);
            {d_m_read_rs, d_m_read_rt, d_s_read_rs, d_s_read_rt} <= r.rd;
            d_m_rs <= r.m_rs;
            d_m_rt <= r.m_rt;
            d_s_rs <= r.s_rs;
            d_s_rt <= r.s_rt;
            e_m_mem_to_reg <= r.em_ld;
            e_m_waddr <= r.em_wa;
            e_s_mem_to_reg <= r.es_ld;
            e_s_waddr <= r.es_wa;
            e_branch_taken <= r.br;
            m_except <= r.exc;
            @(negedge clk);
            check_ena(r.name, r.exp_ena);
            check_flush(r.name, r.exp_flush);
            check_err(r.name, '0);
        end

        // quiet the D/E side before the handshakes
        @(posedge clk);
        {d_m_read_rs, d_m_read_rt, d_s_read_rs, d_s_read_rt} <= 4'b0000;
        e_m_mem_to_reg <= 1'b0;
        e_s_mem_to_reg <= 1'b0;
        e_branch_taken <= 1'b0;
        m_except <= 1'b0;

        delay = 1 + int'($urandom % 8);
        run_handshake("mdu_stall", AGT_MDU, delay, 5'b10000, 3'b000);

        @(posedge clk);
        m_except <= 1'b1;
        delay = 1 + int'($urandom % 8);
        run_handshake("mdu_except", AGT_MDU, delay, 5'b10001, 3'b111);
        @(posedge clk);
        m_except <= 1'b0;

        delay = 1 + int'($urandom % 8);
        run_handshake("icache_stall", AGT_ICACHE, delay, 5'b00000, 3'b000);

        // dcache req dropped before ack
        @(posedge clk);
        dcache_req <= 1'b1;
        @(negedge clk);
        check_ena("early_release", 5'b10000);
        @(posedge clk);
        dcache_req <= 1'b0;
        @(negedge clk);
        check_ena("early_release", 5'b10000); // still waiting on ack
        check_err("early_release", 3'b000);
        @(negedge clk);
        check_err("early_release", 3'b010);
        check_ena("early_release", 5'b11111);
        @(negedge clk);
        check_err("early_release", 3'b000);
        check_ena("early_release", 5'b11111);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: dv/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset low for the first few rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: dv/pipe_hazard_props.sv
module pipe_hazard_props
    import pipe_pkg::*;
(
    input logic                  clk,
    input logic                  rst_n,
    input logic [NUM_AGENTS-1:0] req,
    input logic [NUM_AGENTS-1:0] ack,
    input logic [NUM_AGENTS-1:0] stall,
    input logic [NUM_AGENTS-1:0] proto_err,
    input trk_state_t            st_icache,
    input trk_state_t            st_dcache,
    input trk_state_t            st_mdu
);

    trk_state_t st [NUM_AGENTS];

    assign st[0] = st_icache;
    assign st[1] = st_dcache;
    assign st[2] = st_mdu;

    for (genvar i = 0; i < NUM_AGENTS; i++) begin : g_agent
        // req low two cycles in a row leaves nothing outstanding
        a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
            (!req[i] && !$past(req[i])) |-> !stall[i])
            else $error("stall high with agent %0d idle", i);

        // the stall drops once ack is seen unless a new req is up
        a_stall_drop: assert property (@(posedge clk) disable iff (!rst_n)
            (st[i] == TRK_WAIT_ACK && ack[i]) |=> (!stall[i] || req[i]))
            else $error("stall held after ack on agent %0d", i);

        a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
            proto_err[i] |=> !proto_err[i])
            else $error("proto_err longer than one cycle on agent %0d", i);
    end

endmodule

bind long_stall_tracker pipe_hazard_props props_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .stall     (stall),
    .proto_err (proto_err),
    .st_icache (state_q[0]),
    .st_dcache (state_q[1]),
    .st_mdu    (state_q[2])
);

// File: src/pipe_hazard_top.sv
module pipe_hazard_top
    import pipe_pkg::*;
#(
    parameter bit FETCH_DECOUPLED = 1'b1,
    parameter bit BRANCH_FLUSH_E  = 1'b1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  d_m_read_rs,
    input  logic                  d_m_read_rt,
    input  reg_addr_t             d_m_rs,
    input  reg_addr_t             d_m_rt,
    input  logic                  d_s_read_rs,
    input  logic                  d_s_read_rt,
    input  reg_addr_t             d_s_rs,
    input  reg_addr_t             d_s_rt,
    input  logic                  e_m_mem_to_reg,
    input  reg_addr_t             e_m_waddr,
    input  logic                  e_s_mem_to_reg,
    input  reg_addr_t             e_s_waddr,
    input  logic                  e_branch_taken,
    input  logic                  m_except,
    input  logic                  icache_req,
    input  logic                  icache_ack,
    input  logic                  dcache_req,
    input  logic                  dcache_ack,
    input  logic                  mdu_req,
    input  logic                  mdu_ack,
    output logic                  f_ena,
    output logic                  d_ena,
    output logic                  e_ena,
    output logic                  m_ena,
    output logic                  w_ena,
    output logic                  d_flush,
    output logic                  e_flush,
    output logic                  m_flush,
    output logic [NUM_AGENTS-1:0] proto_err
);

    logic lw_stall;
    logic i_stall;
    logic d_stall;
    logic alu_stall;

    load_use_detect load_use_detect_inst (
        .d_m_read_rs    (d_m_read_rs),
        .d_m_read_rt    (d_m_read_rt),
        .d_s_read_rs    (d_s_read_rs),
        .d_s_read_rt    (d_s_read_rt),
        .d_m_rs         (d_m_rs),
        .d_m_rt         (d_m_rt),
        .d_s_rs         (d_s_rs),
        .d_s_rt         (d_s_rt),
        .e_m_mem_to_reg (e_m_mem_to_reg),
        .e_s_mem_to_reg (e_s_mem_to_reg),
        .e_m_waddr      (e_m_waddr),
        .e_s_waddr      (e_s_waddr),
        .lw_stall       (lw_stall)
    );

    long_stall_tracker long_stall_tracker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .icache_req (icache_req),
        .icache_ack (icache_ack),
        .dcache_req (dcache_req),
        .dcache_ack (dcache_ack),
        .mdu_req    (mdu_req),
        .mdu_ack    (mdu_ack),
        .i_stall    (i_stall),
        .d_stall    (d_stall),
        .alu_stall  (alu_stall),
        .proto_err  (proto_err)
    );

    hazard_combine #(
        .FETCH_DECOUPLED (FETCH_DECOUPLED),
        .BRANCH_FLUSH_E  (BRANCH_FLUSH_E)
    ) hazard_combine_inst (
        .lw_stall       (lw_stall),
        .i_stall        (i_stall),
        .d_stall        (d_stall),
        .alu_stall      (alu_stall),
        .e_branch_taken (e_branch_taken),
        .m_except       (m_except),
        .f_ena          (f_ena),
        .d_ena          (d_ena),
        .e_ena          (e_ena),
        .m_ena          (m_ena),
        .w_ena          (w_ena),
        .d_flush        (d_flush),
        .e_flush        (e_flush),
        .m_flush        (m_flush)
    );

endmodule

// File: src/hazard_combine.sv
module hazard_combine #(
    parameter bit FETCH_DECOUPLED = 1'b1, // fetch queue sits between F and D
    parameter bit BRANCH_FLUSH_E  = 1'b1  // taken branch also squashes E
) (
    input  logic lw_stall,
    input  logic i_stall,
    input  logic d_stall,
    input  logic alu_stall,
    input  logic e_branch_taken,
    input  logic m_except,
    output logic f_ena,
    output logic d_ena,
    output logic e_ena,
    output logic m_ena,
    output logic w_ena,
    output logic d_flush,
    output logic e_flush,
    output logic m_flush
);

    logic long_stall; // any agent outstanding, whole pipe freezes
    logic back_stall; // stalls raised behind the fetch stage
    logic e_br_flush;

    assign long_stall = i_stall | d_stall | alu_stall;
    assign back_stall = d_stall | alu_stall;

    // with a fetch queue, F keeps filling while the back end waits
    assign f_ena = FETCH_DECOUPLED ? ~i_stall : ~(i_stall | back_stall);

    assign d_ena = ~(long_stall | lw_stall);
    assign e_ena = ~long_stall;
    assign m_ena = ~long_stall;

    // an exception in M retires through W even while the mdu holds E
    assign w_ena = ~long_stall | (alu_stall & m_except);

    assign e_br_flush = BRANCH_FLUSH_E & e_branch_taken;

    assign d_flush = m_except | e_branch_taken; // wrong-path slot pair in D
    assign e_flush = m_except | e_br_flush;
    assign m_flush = m_except;

endmodule

// File: src/long_stall_tracker.sv
module long_stall_tracker
    import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  icache_req,
    input  logic                  icache_ack,
    input  logic                  dcache_req,
    input  logic                  dcache_ack,
    input  logic                  mdu_req,
    input  logic                  mdu_ack,
    output logic                  i_stall,
    output logic                  d_stall,
    output logic                  alu_stall,
    output logic [NUM_AGENTS-1:0] proto_err
);

    logic [NUM_AGENTS-1:0] req;
    logic [NUM_AGENTS-1:0] ack;
    logic [NUM_AGENTS-1:0] stall;
    logic [NUM_AGENTS-1:0] early_rel; // req dropped while still waiting

    trk_state_t state_q [NUM_AGENTS];
    trk_state_t state_d [NUM_AGENTS];

    assign req[AGT_ICACHE] = icache_req;
    assign req[AGT_DCACHE] = dcache_req;
    assign req[AGT_MDU]    = mdu_req;

    assign ack[AGT_ICACHE] = icache_ack;
    assign ack[AGT_DCACHE] = dcache_ack;
    assign ack[AGT_MDU]    = mdu_ack;

    always_comb begin
        for (int i = 0; i < NUM_AGENTS; i++) begin
            state_d[i]   = state_q[i];
            early_rel[i] = 1'b0;
            case (state_q[i])
                TRK_IDLE: begin
                    if (req[i]) begin
                        state_d[i] = TRK_WAIT_ACK;
                    end
                end
                TRK_WAIT_ACK: begin
                    // ack wins when req and ack change together
                    if (ack[i]) begin
                        state_d[i] = TRK_WAIT_RELEASE;
                    end else if (!req[i]) begin
                        state_d[i]   = TRK_IDLE; // request abandoned
                        early_rel[i] = 1'b1;
                    end
                end
                TRK_WAIT_RELEASE: begin
                    if (!ack[i]) begin
                        state_d[i] = TRK_IDLE;
                    end
                end
                default: begin
                    state_d[i] = TRK_IDLE;
                end
            endcase
        end
    end

    // stall from the first cycle req is seen, before the state catches up
    always_comb begin
        for (int i = 0; i < NUM_AGENTS; i++) begin
            case (state_q[i])
                TRK_WAIT_ACK:               stall[i] = 1'b1;
                TRK_IDLE, TRK_WAIT_RELEASE: stall[i] = req[i]; // new req pending
                default:                    stall[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AGENTS; i++) begin
                state_q[i] <= TRK_IDLE;
            end
            proto_err <= '0;
        end else begin
            for (int i = 0; i < NUM_AGENTS; i++) begin
                state_q[i] <= state_d[i];
            end
            proto_err <= early_rel; // single-cycle pulse, state is idle after
        end
    end

    assign i_stall   = stall[AGT_ICACHE];
    assign d_stall   = stall[AGT_DCACHE];
    assign alu_stall = stall[AGT_MDU];

endmodule

// File: src/load_use_detect.sv
module load_use_detect
    import pipe_pkg::*;
(
    input  logic      d_m_read_rs,
    input  logic      d_m_read_rt,
    input  logic      d_s_read_rs,
    input  logic      d_s_read_rt,
    input  reg_addr_t d_m_rs,
    input  reg_addr_t d_m_rt,
    input  reg_addr_t d_s_rs,
    input  reg_addr_t d_s_rt,
    input  logic      e_m_mem_to_reg,
    input  logic      e_s_mem_to_reg,
    input  reg_addr_t e_m_waddr,
    input  reg_addr_t e_s_waddr,
    output logic      lw_stall
);

    logic e_m_load; // master E slot holds a load to a real register
    logic e_s_load;

    logic hit_mm_rs; // naming: hit_<D slot><E slot>_<source>
    logic hit_mm_rt;
    logic hit_sm_rs;
    logic hit_sm_rt;
    logic hit_ms_rs;
    logic hit_ms_rt;
    logic hit_ss_rs;
    logic hit_ss_rt;

    // a load to r0 produces nothing worth waiting for
    assign e_m_load = e_m_mem_to_reg & (|e_m_waddr);
    assign e_s_load = e_s_mem_to_reg & (|e_s_waddr);

    // against the master E load
    assign hit_mm_rs = e_m_load & d_m_read_rs & (d_m_rs == e_m_waddr);
    assign hit_mm_rt = e_m_load & d_m_read_rt & (d_m_rt == e_m_waddr);
    assign hit_sm_rs = e_m_load & d_s_read_rs & (d_s_rs == e_m_waddr);
    assign hit_sm_rt = e_m_load & d_s_read_rt & (d_s_rt == e_m_waddr);

    // against the slave E load
    assign hit_ms_rs = e_s_load & d_m_read_rs & (d_m_rs == e_s_waddr);
    assign hit_ms_rt = e_s_load & d_m_read_rt & (d_m_rt == e_s_waddr);
    assign hit_ss_rs = e_s_load & d_s_read_rs & (d_s_rs == e_s_waddr);
    assign hit_ss_rt = e_s_load & d_s_read_rt & (d_s_rt == e_s_waddr);

    // the whole D pair holds if either slot needs a loaded value,
    // since the two slots issue together
    assign lw_stall = hit_mm_rs | hit_mm_rt
                    | hit_sm_rs | hit_sm_rt
                    | hit_ms_rs | hit_ms_rt
                    | hit_ss_rs | hit_ss_rt;

endmodule

// File: src/pipe_pkg.sv
package pipe_pkg;

    // architectural register index, r0 reads as zero and is never a hazard
    typedef logic [4:0] reg_addr_t;

    // long-latency agents watched by the stall tracker
    localparam int NUM_AGENTS = 3;

    // bit positions of each agent in the packed req/ack/stall/err vectors
    localparam int AGT_ICACHE = 0;
    localparam int AGT_DCACHE = 1;
    localparam int AGT_MDU    = 2;

    // four-phase handshake phase of one agent
    // the return-to-zero of ack is tracked separately, so a new req
    // arriving while ack is still high keeps the stall up
    typedef enum logic [1:0] {
        TRK_IDLE         = 2'd0, // no request outstanding
        TRK_WAIT_ACK     = 2'd1, // req seen, result not ready yet
        TRK_WAIT_RELEASE = 2'd2  // ack seen, waiting for ack to drop
    } trk_state_t;

endpackage
